// File: build.f
design/accCtrlPkg.sv
design/instrDecoder.sv
design/stepSequencer.sv
design/controlWordGen.sv
design/accCtrlTop.sv
verif/accCtrl_assert.sv
verif/accCtrlTb.sv

// File: run.sh
#!/bin/bash
# Build and run the accumulator controller testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module accCtrlTb -f build.f -o accCtrlSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/accCtrlSim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation finished: FAIL" sim.log; then
	exit 1
fi
exit 0

// File: verif/accCtrlTb.sv
`default_nettype none
`timescale 1ns/1ns

module accCtrlTb;
	import accCtrlPkg::*;

	localparam int numRandom = 300;
	localparam int timeoutNs = (numRandom + 100) * 10 * 10;	// Tests plus margin

	logic        clk;
	logic        rst;
	logic        instrValid;
	logic        ready;
	instrWord_t  instr;
	dataByte_t   irData;
	ctrlWord_t   ctrl;
	shiftCount_t shiftCount;

	opcode_t aluOps[7] = '{opAdd, opSub, opOr, opAnd, opLoad, opLda, opLdb};
	opcode_t storeOps[3] = '{opStor, opSta, opStb};
	opcode_t keptOps[12] = '{opAdd, opSub, opOr, opAnd, opShft, opLoad, opStor,
		opLda, opSta, opLdb, opStb, opNop};

	accCtrlTop dut_i (
		.clk        (clk),
		.rst        (rst),
		.instrValid (instrValid),
		.instr      (instr),
		.irData     (irData),
		.ready      (ready),
		.ctrl       (ctrl),
		.shiftCount (shiftCount)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		#(timeoutNs);
		$display("Watchdog expired after %0d ns, the run did not complete", timeoutNs);
		$display("Simulation finished: FAIL");
		$finish;
	end

	// One strobe, issued only while ready is high
	task automatic issue(input logic [4:0] op, input logic [2:0] flags, input dataByte_t data);
		@(negedge clk);
		while (!ready) @(negedge clk);
		instrValid = 1'b1;
		instr = {op, flags};
		irData = data;
		@(negedge clk);
		instrValid = 1'b0;
	endtask

	initial begin
		int unsigned gap;
		logic [4:0] op;
		int errors;
		void'($urandom(32'hc262_9bf3));
		rst = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		irData = '0;
		repeat (16) @(negedge clk);
		rst = 1'b0;

		////////////////////////////////////////////////////////////////////////
		// Directed pass
		foreach (aluOps[i]) begin
			for (int m = 0; m < 3; m++) begin
				issue(aluOps[i], 3'(m), 8'($urandom));
			end
		end
		foreach (storeOps[i]) begin
			for (int m = 0; m < 2; m++) begin
				issue(storeOps[i], 3'(m), 8'($urandom));
			end
		end
		for (int m = 0; m < 4; m++) begin
			issue(opShft, 3'(m), 8'($urandom));
		end
		issue(opNop, 3'd0, 8'h00);
		issue(opStor, 3'd2, 8'h5a);	// Immediate store is illegal
		issue(5'b11111, 3'd0, 8'h33);	// Unknown opcode

		////////////////////////////////////////////////////////////////////////
		// Random pass
		for (int n = 0; n < numRandom; n++) begin
			gap = $urandom_range(3, 0);
			repeat (gap) @(negedge clk);
			if ($urandom_range(7, 0) == 0) begin
				op = 5'($urandom);
			end else begin
				op = keptOps[$urandom_range(11, 0)];
			end
			issue(op, 3'($urandom), 8'($urandom));
		end

		@(negedge clk);
		while (!ready) @(negedge clk);
		repeat (4) @(negedge clk);
		errors = dut_i.assert_i.errorCount;
		$display("Run complete with %0d assertion errors", errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/accCtrl_assert.sv
`default_nettype none
`timescale 1ns/1ns

module accCtrlAssert (
	input logic                    clk,
	input logic                    rst,
	input logic                    instrValid,
	input accCtrlPkg::instrWord_t  instr,
	input accCtrlPkg::dataByte_t   irData,
	input logic                    ready,
	input accCtrlPkg::ctrlWord_t   ctrl,
	input accCtrlPkg::shiftCount_t shiftCount
);
	import accCtrlPkg::*;

	int errorCount = 0;
	opcode_t op;
	logic [2:0] fl;
	opClass_t nxtClass, expClass;
	aluOp_t nxtAlu, expAlu;
	int nxtLen, nxtReads, expLen, expReads;
	logic expImm, expLeft, expFill, armed;
	shiftCount_t expCount;
	int busyCnt, accCnt, readCnt, writeCnt, mdrCnt, shiftCnt;
	logic inWindow;	// Ctrl sample belongs to the current instruction

	assign op = opcode_t'(instr[7:3]);
	assign fl = instr[2:0];
	assign inWindow = !ready && busyCnt != 0;

	////////////////////////////////////////////////////////////////////////////
	// Expected class, length and reads of the instruction on the bus

	always_comb begin
		nxtClass = classBubble;
		nxtLen = 1;
		nxtReads = 0;
		case (op)
			opAdd: nxtAlu = aluAdd;
			opSub: nxtAlu = aluSub;
			opOr: nxtAlu = aluOr;
			opAnd: nxtAlu = aluAnd;
			opLoad, opLda, opLdb: nxtAlu = aluPass;
			default: nxtAlu = aluNone;
		endcase
		if (nxtAlu != aluNone && fl <= 3'd2) begin
			nxtClass = classAlu;
			nxtLen = (fl == 3'd2) ? 2 : (fl == 3'd1) ? 7 : 4;
			nxtReads = (fl == 3'd2) ? 0 : (fl == 3'd1) ? 2 : 1;
		end else if ((op == opStor || op == opSta || op == opStb) && fl <= 3'd1) begin
			nxtClass = classStore;
			nxtLen = (fl == 3'd1) ? 7 : 4;
		end else if (op == opShft && fl <= 3'd3) begin
			nxtClass = classShift;
			nxtLen = 2;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			armed <= 1'b0;
			busyCnt <= 0;
		end else if (instrValid && ready) begin
			armed <= 1'b1;
			busyCnt <= 0;
			{accCnt, readCnt, writeCnt} <= '0;
			{mdrCnt, shiftCnt} <= '0;
			expClass <= nxtClass;
			expLen <= nxtLen;
			expReads <= nxtReads;
			expAlu <= nxtAlu;
			expImm <= (fl == 3'd2);
			expLeft <= ~fl[1];	// Flag bit 1 selects right
			expFill <= fl[0];
			expCount <= irData[2:0];
		end else begin
			if (!ready) busyCnt <= busyCnt + 1;
			if (inWindow) begin
				accCnt <= accCnt + int'(ctrl.accWrite);
				readCnt <= readCnt + int'(ctrl.memRead);
				writeCnt <= writeCnt + int'(ctrl.memWrite);
				mdrCnt <= mdrCnt + int'(ctrl.accToMdr);
				shiftCnt <= shiftCnt + int'(ctrl.shiftEn);
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks, most made when ready returns high

	resetQuiet: assert property (@(posedge clk) rst |=> ctrl == '0 && shiftCount == '0 && ready)
		else begin
			$error("** Error %0t: ctrl %h, shiftCount %0d, ready %b at reset, expected 0, 0, 1",
				$time, $sampled(ctrl), $sampled(shiftCount), $sampled(ready));
			errorCount++;
		end
	strobeReady: assert property (@(posedge clk) disable iff (rst) instrValid |-> ready)
		else begin
			$error("Instruction strobe arrived while ready was low");
			errorCount++;
		end
	busyLen: assert property (@(posedge clk) disable iff (rst)
		$rose(ready) && armed |-> busyCnt == expLen)
		else begin
			$error("** Error %0t: busy cycles is %0d, expected %0d", $time,
				$sampled(busyCnt), $sampled(expLen));
			errorCount++;
		end
	aluPulse: assert property (@(posedge clk) disable iff (rst)
		$rose(ready) && armed && expClass == classAlu |-> ctrl.accWrite && accCnt == 0)
		else begin
			$error("ALU instruction did not end with exactly one accWrite pulse");
			errorCount++;
		end
	aluOpOk: assert property (@(posedge clk) disable iff (rst)
		$rose(ready) && armed && expClass == classAlu |-> ctrl.aluOp == expAlu)
		else begin
			$error("** Error %0t: ctrl.aluOp is %0d, expected %0d", $time,
				$sampled(ctrl.aluOp), $sampled(expAlu));
			errorCount++;
		end
	aluImm: assert property (@(posedge clk) disable iff (rst)
		$rose(ready) && armed && expClass == classAlu |-> ctrl.operandImm == expImm)
		else begin
			$error("** Error %0t: ctrl.operandImm is %b, expected %b", $time,
				$sampled(ctrl.operandImm), $sampled(expImm));
			errorCount++;
		end
	aluReads: assert property (@(posedge clk) disable iff (rst)
		$rose(ready) && armed && expClass == classAlu |-> readCnt + int'(ctrl.memRead) == expReads)
		else begin
			$error("** Error %0t: memRead count is %0d, expected %0d", $time,
				$sampled(readCnt) + int'($sampled(ctrl.memRead)), $sampled(expReads));
			errorCount++;
		end
	storeWrite: assert property (@(posedge clk) disable iff (rst)
		$rose(ready) && armed && expClass == classStore |-> writeCnt + int'(ctrl.memWrite) == 1)
		else begin
			$error("** Error %0t: memWrite count is %0d, expected 1", $time,
				$sampled(writeCnt) + int'($sampled(ctrl.memWrite)));
			errorCount++;
		end
	storeMdr: assert property (@(posedge clk) disable iff (rst)
		$rose(ready) && armed && expClass == classStore |-> mdrCnt + int'(ctrl.accToMdr) == 1)
		else begin
			$error("** Error %0t: accToMdr count is %0d, expected 1", $time,
				$sampled(mdrCnt) + int'($sampled(ctrl.accToMdr)));
			errorCount++;
		end
	storeNoAcc: assert property (@(posedge clk) disable iff (rst)
		$rose(ready) && armed && expClass == classStore |-> accCnt == 0 && !ctrl.accWrite)
		else begin
			$error("Store instruction raised accWrite");
			errorCount++;
		end
	storeOrder: assert property (@(posedge clk) disable iff (rst) inWindow && ctrl.memWrite |-> mdrCnt == 1)
		else begin
			$error("Store wrote memory before moving the accumulator to the MDR");
			errorCount++;
		end
	shiftPulse: assert property (@(posedge clk) disable iff (rst)
		$rose(ready) && armed && expClass == classShift |-> ctrl.shiftEn && shiftCnt == 0)
		else begin
			$error("Shift instruction did not end with exactly one shiftEn pulse");
			errorCount++;
		end
	shiftCountOk: assert property (@(posedge clk) disable iff (rst)
		$rose(ready) && armed && expClass == classShift |-> shiftCount == expCount)
		else begin
			$error("** Error %0t: shiftCount is %0d, expected %0d", $time,
				$sampled(shiftCount), $sampled(expCount));
			errorCount++;
		end
	shiftDir: assert property (@(posedge clk) disable iff (rst)
		$rose(ready) && armed && expClass == classShift |->
		ctrl.shiftLeft == expLeft && ctrl.shiftFill == expFill)
		else begin
			$error("** Error %0t: ctrl.shiftLeft, shiftFill are %b %b, expected %b %b", $time,
				$sampled(ctrl.shiftLeft), $sampled(ctrl.shiftFill),
				$sampled(expLeft), $sampled(expFill));
			errorCount++;
		end
	bubbleQuiet: assert property (@(posedge clk) disable iff (rst)
		$rose(ready) && armed && expClass == classBubble |-> ctrl == '0)
		else begin
			$error("** Error %0t: ctrl is %h in a bubble, expected 0", $time, $sampled(ctrl));
			errorCount++;
		end

endmodule

bind accCtrlTop accCtrlAssert assert_i (
	.clk        (clk),
	.rst        (rst),
	.instrValid (instrValid),
	.instr      (instr),
	.irData     (irData),
	.ready      (ready),
	.ctrl       (ctrl),
	.shiftCount (shiftCount)
);

`default_nettype wire

// File: design/accCtrlTop.sv
`default_nettype none
`timescale 1ns/1ns

module accCtrlTop (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    instrValid,	// One-cycle strobe, only while ready
	input  accCtrlPkg::instrWord_t  instr,
	input  accCtrlPkg::dataByte_t   irData,
	output logic                    ready,
	output accCtrlPkg::ctrlWord_t   ctrl,
	output accCtrlPkg::shiftCount_t shiftCount
);
	import accCtrlPkg::*;

	decodedInstr_t decoded;
	decodedInstr_t held;
	step_t         step;

	instrDecoder decoder_i (
		.instr   (instr),
		.irData  (irData),
		.decoded (decoded)
	);

	stepSequencer sequencer_i (
		.clk        (clk),
		.rst        (rst),
		.instrValid (instrValid),
		.decoded    (decoded),
		.step       (step),
		.held       (held),
		.ready      (ready)
	);

	controlWordGen ctrlGen_i (
		.clk        (clk),
		.rst        (rst),
		.step       (step),
		.held       (held),
		.ctrl       (ctrl),
		.shiftCount (shiftCount)
	);

endmodule

`default_nettype wire

// File: design/controlWordGen.sv
`default_nettype none
`timescale 1ns/1ns

module controlWordGen (
	input  logic                      clk,
	input  logic                      rst,
	input  accCtrlPkg::step_t         step,
	input  accCtrlPkg::decodedInstr_t held,
	output accCtrlPkg::ctrlWord_t     ctrl,
	output accCtrlPkg::shiftCount_t   shiftCount
);
	import accCtrlPkg::*;

	ctrlWord_t   ctrlNext;
	shiftCount_t countNext;

	////////////////////////////////////////////////////////////////////////////
	// Step decode

	always_comb begin
		ctrlNext = '0;
		countNext = '0;
		case (step)
			stepAddrOut, stepAddrOut2: begin
				ctrlNext.marLoad = 1'b1;
			end
			stepMemRead, stepMemRead2: begin
				ctrlNext.memRead = 1'b1;
				ctrlNext.mdrLoad = 1'b1;	// Capture read data
			end
			stepAccToMdr: begin
				ctrlNext.accToMdr = 1'b1;
			end
			stepMemWrite: begin
				ctrlNext.memWrite = 1'b1;
			end
			stepExecute: begin
				if (held.opClass == classShift) begin
					ctrlNext.shiftEn = 1'b1;
					ctrlNext.shiftLeft = held.shiftLeft;
					ctrlNext.shiftFill = held.shiftFill;
					countNext = held.shiftCount;
				end else begin
					ctrlNext.accWrite = 1'b1;
					ctrlNext.aluOp = held.aluOp;
					ctrlNext.operandImm = (held.addrMode == modeImm);
				end
			end
			default: begin
				// Latch, setup and bubble steps drive nothing
				ctrlNext = '0;
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Output register

	always_ff @(posedge clk) begin
		if (rst) begin
			ctrl <= '0;
			shiftCount <= '0;
		end else begin
			ctrl <= ctrlNext;
			shiftCount <= countNext;
		end
	end

endmodule

`default_nettype wire

// File: design/stepSequencer.sv
`default_nettype none
`timescale 1ns/1ns

module stepSequencer (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      instrValid,
	input  accCtrlPkg::decodedInstr_t decoded,
	output accCtrlPkg::step_t         step,
	output accCtrlPkg::decodedInstr_t held,
	output logic                      ready
);
	import accCtrlPkg::*;

	seqIdx_t stepIdx;	// Index of the next step
	seqIdx_t seqLen;

	////////////////////////////////////////////////////////////////////////////
	// Sequence tables

	function automatic step_t stepAt(decodedInstr_t d, seqIdx_t idx);
		step_t s;
		s = stepBubble;
		case (d.opClass)
			classShift: s = (idx == 3'd0) ? stepShiftSetup : stepExecute;
			classAlu: begin
				if (d.addrMode == modeImm) begin
					s = (idx == 3'd0) ? stepImmLatch : stepExecute;
				end else if (d.addrMode == modeInd) begin
					case (idx)
						3'd0: s = stepAddrOut;
						3'd1: s = stepMemRead;
						3'd2: s = stepPtrLatch;
						3'd3: s = stepAddrOut2;
						3'd4: s = stepMemRead2;
						3'd5: s = stepOperandLatch;
						default: s = stepExecute;
					endcase
				end else begin
					case (idx)
						3'd0: s = stepAddrOut;
						3'd1: s = stepMemRead;
						3'd2: s = stepOperandLatch;
						default: s = stepExecute;
					endcase
				end
			end
			classStore: begin
				if (d.addrMode == modeInd) begin
					case (idx)
						3'd0: s = stepAddrOut;
						3'd1: s = stepMemRead;	// Pointer fetch
						3'd2: s = stepPtrLatch;
						3'd3: s = stepAddrOut2;
						3'd4: s = stepAccToMdr;
						3'd5: s = stepMemWrite;
						default: s = stepBubble;
					endcase
				end else begin
					case (idx)
						3'd0: s = stepAddrOut;
						3'd1: s = stepAccToMdr;
						3'd2: s = stepMemWrite;
						default: s = stepBubble;
					endcase
				end
			end
			default: s = stepBubble;
		endcase
		return s;
	endfunction

	function automatic seqIdx_t lenOf(decodedInstr_t d);
		seqIdx_t len;
		case (d.opClass)
			classShift: len = lenImm;
			classAlu: len = (d.addrMode == modeImm) ? lenImm :
				(d.addrMode == modeInd) ? lenIndirect : lenDirect;
			classStore: len = (d.addrMode == modeInd) ? lenIndirect : lenDirect;
			default: len = lenBubble;
		endcase
		return len;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Step register

	always_ff @(posedge clk) begin
		if (rst) begin
			step <= stepIdle;
			stepIdx <= '0;
		end else if (step == stepIdle) begin
			if (instrValid) begin
				step <= stepAt(decoded, 3'd0);
				stepIdx <= 3'd1;
			end
		end else if (stepIdx == seqLen) begin
			step <= stepIdle;	// Last step done
		end else begin
			step <= stepAt(held, stepIdx);
			stepIdx <= stepIdx + 3'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (instrValid && ready) begin
			held <= decoded;
			seqLen <= lenOf(decoded);
		end
	end

	assign ready = (step == stepIdle);

endmodule

`default_nettype wire

// File: design/instrDecoder.sv
`default_nettype none
`timescale 1ns/1ns

module instrDecoder (
	input  accCtrlPkg::instrWord_t    instr,
	input  accCtrlPkg::dataByte_t     irData,
	output accCtrlPkg::decodedInstr_t decoded
);
	import accCtrlPkg::*;

	opcode_t    opcode;
	logic [2:0] flags;
	logic       modeOk;	// Direct, indirect or immediate
	logic       storeModeOk;

	assign opcode = opcode_t'(instr[7:3]);
	assign flags = instr[2:0];
	assign modeOk = (flags <= 3'd2);
	assign storeModeOk = (flags <= 3'd1);	// No immediate store

	always_comb begin
		decoded.opClass = classBubble;
		decoded.addrMode = addrMode_t'(flags);
		decoded.aluOp = aluNone;
		decoded.shiftLeft = ~flags[1];
		decoded.shiftFill = flags[0];
		decoded.shiftCount = irData[2:0];

		case (opcode)
			opAdd: decoded.aluOp = aluAdd;
			opSub: decoded.aluOp = aluSub;
			opOr: decoded.aluOp = aluOr;
			opAnd: decoded.aluOp = aluAnd;
			opLoad, opLda, opLdb: decoded.aluOp = aluPass;	// Loads pass the operand
			default: decoded.aluOp = aluNone;
		endcase

		if (decoded.aluOp != aluNone && modeOk) begin
			decoded.opClass = classAlu;
		end else if ((opcode == opStor || opcode == opSta || opcode == opStb) && storeModeOk) begin
			decoded.opClass = classStore;
		end else if (opcode == opShft && !flags[2]) begin
			decoded.opClass = classShift;
		end
		// NOP, unknown opcodes and bad flags stay a bubble
	end

endmodule

`default_nettype wire

// File: design/accCtrlPkg.sv
`default_nettype none

package accCtrlPkg;

	////////////////////////////////////////////////////////////////////////////
	// Instruction fields

	typedef logic [7:0] instrWord_t;	// Opcode in [7:3], flags in [2:0]
	typedef logic [7:0] dataByte_t;
	typedef logic [2:0] shiftCount_t;
	typedef logic [2:0] seqIdx_t;	// Position inside a step sequence

	typedef enum logic [4:0] {
		opAdd  = 5'b00000,
		opSub  = 5'b00001,
		opOr   = 5'b00011,
		opAnd  = 5'b00100,
		opShft = 5'b00101,
		opLoad = 5'b01010,
		opStor = 5'b01011,
		opNop  = 5'b01111,
		opLda  = 5'b10001,
		opSta  = 5'b10010,
		opLdb  = 5'b10011,
		opStb  = 5'b10100
	} opcode_t;

	// Shifts reuse this field: bit 1 selects right, bit 0 the fill value
	typedef enum logic [2:0] {
		modeDir = 3'd0,
		modeInd = 3'd1,
		modeImm = 3'd2
	} addrMode_t;

	typedef enum logic [2:0] {aluNone, aluAdd, aluSub, aluOr, aluAnd, aluPass} aluOp_t;

	typedef enum logic [1:0] {classAlu, classStore, classShift, classBubble} opClass_t;

	typedef enum logic [3:0] {
		stepIdle,
		stepAddrOut, stepMemRead, stepPtrLatch,	// Operand or pointer fetch
		stepAddrOut2, stepMemRead2, stepOperandLatch,	// Second fetch when indirect
		stepAccToMdr, stepMemWrite,
		stepImmLatch, stepShiftSetup,
		stepExecute, stepBubble
	} step_t;

	////////////////////////////////////////////////////////////////////////////
	// Structs

	typedef struct packed {
		opClass_t    opClass;
		addrMode_t   addrMode;
		aluOp_t      aluOp;
		logic        shiftLeft;
		logic        shiftFill;
		shiftCount_t shiftCount;
	} decodedInstr_t;

	typedef struct packed {
		logic   memRead;
		logic   memWrite;
		logic   marLoad;
		logic   mdrLoad;
		logic   accWrite;
		logic   accToMdr;
		logic   operandImm;	// ALU B operand from IR data
		logic   shiftEn;
		logic   shiftLeft;
		logic   shiftFill;
		aluOp_t aluOp;
	} ctrlWord_t;

	// Busy cycles per sequence
	localparam seqIdx_t lenBubble   = 3'd1;
	localparam seqIdx_t lenImm      = 3'd2;	// Also shifts
	localparam seqIdx_t lenDirect   = 3'd4;	// Also direct stores
	localparam seqIdx_t lenIndirect = 3'd7;

endpackage

`default_nettype wire
